// File: verilog.f
+incdir+include
logic/cart_pkg.sv
logic/rom_write_ctrl.sv
logic/cart_header_scan.sv
logic/region_select.sv
logic/cart_quirk_table.sv
logic/cheat_code_loader.sv
logic/cart_loader_top.sv
testbench/tb_clock_gen.sv
testbench/cart_loader_sva.sv
testbench/cart_loader_tb.sv

// File: Bender.yml
package:
  name: cart_loader

export_include_dirs:
  - include

sources:
  - files:
      - logic/cart_pkg.sv
      - logic/rom_write_ctrl.sv
      - logic/cart_header_scan.sv
      - logic/region_select.sv
      - logic/cart_quirk_table.sv
      - logic/cheat_code_loader.sv
      - logic/cart_loader_top.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/cart_loader_sva.sv
      - testbench/cart_loader_tb.sv

// File: testbench/cart_loader_tb.sv
/*
 * Directed tests for ROM load, region choice, quirk lookup and cheat codes
 * with a ROM memory model and watchdog
 */
`timescale 1ns/1ps
`default_nettype none
`include "cart_defs.svh"

module cart_loader_tb import cart_pkg::*; ();

	localparam int CLK_PERIOD_NS   = 4;
	localparam int ROM_WORDS       = 600;
	localparam int TOTAL_WORDS     = ROM_WORDS + 80;
	localparam int WORD_WAIT_LIMIT = 32;
	localparam int WATCHDOG_NS     = (TOTAL_WORDS * 12 + 400) * CLK_PERIOD_NS;
	localparam logic [31:0] LFSR_TAPS = 32'h80200003;

	logic                     clk_sys;
	logic                     reset;
	logic                     ioctl_download = 1'b0;
	logic [`CART_INDEX_W-1:0] ioctl_index = '0;
	logic                     ioctl_wr = 1'b0;
	logic [`CART_ADDR_W-1:0]  ioctl_addr = '0;
	logic [`CART_DATA_W-1:0]  ioctl_data = '0;
	logic                     ioctl_wait;
	logic                     rom_wr_req;
	logic [`CART_ADDR_W-1:0]  rom_wr_addr;
	logic [`CART_DATA_W-1:0]  rom_wr_data;
	logic                     rom_wr_ack = 1'b0;
	region_mode_t             region_mode = MODE_HEADER;
	region_prio_t             region_prio = PRIO_US_EU_JP;
	region_t                  region;
	logic                     region_set;
	logic [`CART_ADDR_W-1:0]  rom_size;
	cart_quirks_t             quirks;
	cheat_code_t              code;
	logic                     code_valid;
	logic                     code_reset;

	logic [31:0] lfsr_state = 32'd66573;
	logic [15:0] rom_mem [0:1023];
	int          errors = 0;
	int          words_written = 0;
	int          valid_count = 0;
	int          reset_count = 0;
	int          req_toggles = 0;
	logic        req_seen = 1'b0;

	tb_clock_gen #(.HALF_PERIOD_NS(CLK_PERIOD_NS / 2), .RESET_CYCLES(8)) clock_i (
		.clk_sys(clk_sys),
		.reset(reset)
	);

	cart_loader_top dut_i (
		.clk_sys(clk_sys), .reset(reset),
		.ioctl_download(ioctl_download), .ioctl_index(ioctl_index),
		.ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr), .ioctl_data(ioctl_data),
		.ioctl_wait(ioctl_wait),
		.rom_wr_req(rom_wr_req), .rom_wr_addr(rom_wr_addr), .rom_wr_data(rom_wr_data),
		.rom_wr_ack(rom_wr_ack),
		.region_mode(region_mode), .region_prio(region_prio),
		.region(region), .region_set(region_set), .rom_size(rom_size),
		.quirks(quirks), .code(code), .code_valid(code_valid), .code_reset(code_reset)
	);

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
		end
		return v;
	endfunction

	////////////////////
	// ROM memory model with random acknowledge latency
	logic download_seen = 1'b0;
	logic ack_busy = 1'b0;
	int   ack_delay = 0;

	always @(posedge clk_sys) begin
		download_seen <= ioctl_download;
		if (reset) begin
			rom_wr_ack <= 1'b0;
			ack_busy = 1'b0;
		end else if (ioctl_download && !download_seen && ioctl_index != `CODE_INDEX) begin
			// Request side restarts from 0 on a fresh cart download
			rom_wr_ack <= 1'b0;
			ack_busy = 1'b0;
		end else if (rom_wr_req != rom_wr_ack) begin
			if (!ack_busy) begin
				ack_busy = 1'b1;
				ack_delay = random_bits(2);
			end
			if (ack_delay == 0) begin
				rom_mem[rom_wr_addr[10:1]] <= rom_wr_data;
				rom_wr_ack <= rom_wr_req;
				ack_busy = 1'b0;
			end else begin
				ack_delay--;
			end
		end
	end

	// Pulse and toggle counters for the cheat code test
	always @(posedge clk_sys) begin
		if (code_valid)
			valid_count++;
		if (code_reset)
			reset_count++;
		if (rom_wr_req != req_seen)
			req_toggles++;
		req_seen = rom_wr_req;
	end

	////////////////////
	task automatic report_mismatch(input string name, input logic [127:0] got,
	                               input logic [127:0] exp);
		errors++;
		$display("[FAIL] t=%0t %s got %0h expected %0h", $time, name, got, exp);
	endtask

	task automatic report_error(input string what);
		errors++;
		$display("ERROR at %0t: %s", $time, what);
	endtask

	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic begin_download(input logic [`CART_INDEX_W-1:0] index);
		ioctl_index = index;
		ioctl_download = 1'b1;
		next_cycle();
	endtask

	// Address stays on the last word so the size latch can see it
	task automatic end_download();
		ioctl_download = 1'b0;
		next_cycle();
	endtask

	task automatic write_word(input logic [`CART_ADDR_W-1:0] addr,
	                          input logic [`CART_DATA_W-1:0] data);
		int cycles;
		ioctl_addr = addr;
		ioctl_data = data;
		ioctl_wr = 1'b1;
		next_cycle();
		ioctl_wr = 1'b0;
		words_written++;
		cycles = 0;
		while (ioctl_wait && cycles < WORD_WAIT_LIMIT) begin
			next_cycle();
			cycles++;
		end
		if (ioctl_wait)
			report_error($sformatf("ioctl_wait never fell after word at %0h", addr));
	endtask

	// First flagged region in the search order, else its head
	function automatic region_t expected_region(input region_prio_t prio,
	                                            input logic j, input logic u, input logic e);
		case (prio)
			PRIO_US_EU_JP: return u ? REGION_US : e ? REGION_EU : j ? REGION_JP : REGION_US;
			PRIO_EU_US_JP: return e ? REGION_EU : u ? REGION_US : j ? REGION_JP : REGION_EU;
			PRIO_US_JP_EU: return u ? REGION_US : j ? REGION_JP : e ? REGION_EU : REGION_US;
			default:       return j ? REGION_JP : u ? REGION_US : e ? REGION_EU : REGION_JP;
		endcase
	endfunction

	////////////////////
	task automatic rom_load_test();
		logic [15:0] words [ROM_WORDS];
		logic [15:0] swapped;
		begin_download(8'h01);
		for (int i = 0; i < ROM_WORDS; i++) begin
			words[i] = random_bits(16);
			write_word(2 * i, words[i]);
		end
		end_download();
		if (rom_wr_addr !== 2 * (ROM_WORDS - 1))
			report_mismatch("rom_wr_addr", rom_wr_addr, 2 * (ROM_WORDS - 1));
		if (rom_size !== 2 * (ROM_WORDS - 1))
			report_mismatch("rom_size", rom_size, 2 * (ROM_WORDS - 1));
		if (ioctl_wait !== 1'b0)
			report_mismatch("ioctl_wait", ioctl_wait, 1'b0);
		for (int i = 0; i < ROM_WORDS; i++) begin
			swapped = {words[i][7:0], words[i][15:8]};
			if (rom_mem[i] !== swapped)
				report_mismatch($sformatf("rom_mem[%0h]", 2 * i), rom_mem[i], swapped);
		end
	endtask

	task automatic header_region_test(input region_prio_t prio, input logic [7:0] hi0,
	                                  input logic [7:0] lo0, input logic [7:0] lo1,
	                                  input logic j, input logic u, input logic e);
		region_t exp;
		exp = expected_region(prio, j, u, e);
		region_mode = MODE_HEADER;
		region_prio = prio;
		begin_download(8'h00);
		write_word(`HDR_REGION_ADDR0, {hi0, lo0});
		write_word(`HDR_REGION_ADDR1, {8'h20, lo1});
		write_word(`HDR_READY_ADDR, 16'h0000);
		if (region_set !== 1'b1)
			report_mismatch("region_set", region_set, 1'b1);
		if (region !== exp)
			report_mismatch("region", region, exp);
		end_download();
		next_cycle();
		if (region_set !== 1'b0)
			report_mismatch("region_set", region_set, 1'b0);
	endtask

	task automatic file_index_region_test(input logic [`CART_INDEX_W-1:0] index,
	                                      input logic exp_set, input region_t exp_region);
		region_mode = MODE_FILE_INDEX;
		begin_download(index);
		write_word(`HDR_READY_ADDR, 16'h0000);
		if (region_set !== exp_set)
			report_mismatch("region_set", region_set, exp_set);
		if (exp_set && region !== exp_region)
			report_mismatch("region", region, exp_region);
		end_download();
		next_cycle();
	endtask

	// Character k of the code sits at byte address 0x183 + k
	task automatic write_product_code(input logic [63:0] product);
		logic [7:0] bytes [10];
		bytes[0] = 8'h20;
		bytes[9] = 8'h20;
		for (int k = 0; k < 8; k++)
			bytes[k + 1] = product[63 - 8 * k -: 8];
		for (int w = 0; w < 5; w++)
			write_word(`HDR_ID_FIRST + 2 * w, {bytes[2 * w + 1], bytes[2 * w]});
		write_word(`HDR_ID_DECIDE, 16'h0000);
	endtask

	task automatic quirk_test(input logic [63:0] product, input cart_quirks_t exp);
		begin_download(8'h00);
		if (quirks !== '0)
			report_mismatch("quirks at download start", quirks, 8'h00);
		write_product_code(product);
		if (quirks !== exp)
			report_mismatch("quirks", quirks, exp);
		end_download();
	endtask

	task automatic cheat_code_test();
		logic [15:0] w [8];
		cheat_code_t exp;
		valid_count = 0;
		reset_count = 0;
		req_toggles = 0;
		begin_download(`CODE_INDEX);
		for (int i = 0; i < 8; i++) begin
			w[i] = random_bits(16);
			write_word(2 * i, w[i]);
		end
		exp.flags   = {w[1], w[0]};
		exp.address = {w[3], w[2]};
		exp.compare = {w[5], w[4]};
		exp.replace = {w[7], w[6]};
		next_cycle();
		end_download();
		next_cycle();
		if (code !== exp)
			report_mismatch("code", code, exp);
		if (valid_count != 1)
			report_mismatch("code_valid pulses", valid_count, 1);
		if (reset_count != 1)
			report_mismatch("code_reset pulses", reset_count, 1);
		if (req_toggles != 0)
			report_error($sformatf("rom_wr_req toggled %0d times in a code download",
			                       req_toggles));
	endtask

	////////////////////
	initial begin
		cart_quirks_t sram_only;
		sram_only = '0;
		sram_only.sram = 1'b1;
		@(negedge reset);
		next_cycle();
		if (ioctl_wait !== 1'b0 || rom_wr_req !== 1'b0 || region_set !== 1'b0)
			report_error("host or region outputs not low after reset");
		if (code_valid !== 1'b0 || code_reset !== 1'b0)
			report_error("cheat code pulses not low after reset");
		if (quirks !== '0)
			report_mismatch("quirks", quirks, 8'h00);

		rom_load_test();

		header_region_test(PRIO_US_EU_JP, "J", " ", " ", 1'b1, 1'b0, 1'b0);
		header_region_test(PRIO_JP_US_EU, "U", "J", " ", 1'b1, 1'b1, 1'b0);
		header_region_test(PRIO_EU_US_JP, "U", " ", "E", 1'b0, 1'b1, 1'b1);
		header_region_test(PRIO_US_JP_EU, " ", "5", "J", 1'b1, 1'b0, 1'b1);
		header_region_test(PRIO_EU_US_JP, " ", " ", " ", 1'b0, 1'b0, 1'b0);
		header_region_test(PRIO_US_EU_JP, "J", "E", "U", 1'b1, 1'b1, 1'b1);

		// Index bits 7 to 6 carry the region
		file_index_region_test(8'h80, 1'b1, REGION_EU);
		file_index_region_test(8'h00, 1'b0, REGION_JP);

		quirk_test("T-081276", sram_only);
		quirk_test("ABCD-123", '0);

		cheat_code_test();

		errors += dut_i.sva_i.failures;
		$display("Done: %0d words written, %0d errors", words_written, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	// Bound on the whole run from the number of words written
	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog: run did not finish within %0d ns", WATCHDOG_NS);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/cart_loader_sva.sv
/*
 * Concurrent assertions on the loader top level, attached by bind
 */
`timescale 1ns/1ps
`default_nettype none

module cart_loader_sva (
	input wire clk_sys,
	input wire reset,
	input wire ioctl_wr,
	input wire ioctl_wait,
	input wire code_valid,
	input wire region_set,
	input wire header_ready
);

	int unsigned failures = 0;

	// Host is only held after it wrote a word
	wait_after_write: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(ioctl_wait) |-> $past(ioctl_wr))
		else begin
			$error("ioctl_wait rose without ioctl_wr in the cycle before");
			failures++;
		end

	valid_one_cycle: assert property (@(posedge clk_sys) disable iff (reset)
		code_valid |=> !code_valid)
		else begin
			$error("code_valid stayed high for more than one cycle");
			failures++;
		end

	// region_set drops one cycle after header_ready
	set_needs_header: assert property (@(posedge clk_sys) disable iff (reset)
		region_set |-> (header_ready || $past(header_ready)))
		else begin
			$error("region_set high without a ready header");
			failures++;
		end

endmodule

bind cart_loader_top cart_loader_sva sva_i (
	.clk_sys, .reset, .ioctl_wr, .ioctl_wait, .code_valid, .region_set, .header_ready
);

`default_nettype wire

// File: testbench/tb_clock_gen.sv
/*
 * Testbench clock and power-on reset
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int HALF_PERIOD_NS = 2,
	parameter int RESET_CYCLES   = 8
) (
	output logic clk_sys,
	output logic reset
);

	initial begin
		clk_sys = 1'b0;
		forever #(HALF_PERIOD_NS) clk_sys = ~clk_sys;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		#1;
		reset = 1'b0;
	end

endmodule

`default_nettype wire

// File: logic/cart_loader_top.sv
/*
 * Cartridge loader top level, download kind decode and block wiring
 */
`timescale 1ns/1ps
`default_nettype none
`include "cart_defs.svh"

module cart_loader_top import cart_pkg::*; (
	input  wire                     clk_sys,
	input  wire                     reset,
	input  wire                     ioctl_download,
	input  wire [`CART_INDEX_W-1:0] ioctl_index,
	input  wire                     ioctl_wr,
	input  wire [`CART_ADDR_W-1:0]  ioctl_addr,
	input  wire [`CART_DATA_W-1:0]  ioctl_data,
	output logic                    ioctl_wait,
	output logic                    rom_wr_req,
	output logic [`CART_ADDR_W-1:0] rom_wr_addr,
	output logic [`CART_DATA_W-1:0] rom_wr_data,
	input  wire                     rom_wr_ack,
	input  wire region_mode_t       region_mode,
	input  wire region_prio_t       region_prio,
	output region_t                 region,
	output logic                    region_set,
	output logic [`CART_ADDR_W-1:0] rom_size,
	output cart_quirks_t            quirks,
	output cheat_code_t             code,
	output logic                    code_valid,
	output logic                    code_reset
);

	logic code_index;
	logic cart_download;
	logic code_download;
	logic hdr_j;
	logic hdr_u;
	logic hdr_e;
	logic header_ready;

	// Everything but the code index is a cartridge image
	assign code_index    = (ioctl_index == `CODE_INDEX);
	assign cart_download = ioctl_download & ~code_index;
	assign code_download = ioctl_download & code_index;

	////////////////////
	rom_write_ctrl rom_write_ctrl_i (
		.clk_sys, .reset, .cart_download, .ioctl_wr, .ioctl_addr, .ioctl_data,
		.rom_wr_ack, .ioctl_wait, .rom_wr_req, .rom_wr_addr, .rom_wr_data, .rom_size
	);

	cart_header_scan cart_header_scan_i (
		.clk_sys, .reset, .cart_download, .ioctl_wr, .ioctl_addr, .ioctl_data,
		.hdr_j, .hdr_u, .hdr_e, .header_ready
	);

	region_select region_select_i (
		.clk_sys, .reset, .region_mode, .region_prio, .ioctl_index,
		.hdr_j, .hdr_u, .hdr_e, .header_ready, .region, .region_set
	);

	cart_quirk_table cart_quirk_table_i (
		.clk_sys, .reset, .cart_download, .ioctl_wr, .ioctl_addr, .ioctl_data, .quirks
	);

	cheat_code_loader cheat_code_loader_i (
		.clk_sys, .reset, .code_download, .ioctl_wr, .ioctl_addr, .ioctl_data,
		.code, .code_valid, .code_reset
	);

endmodule

`default_nettype wire

// File: logic/cheat_code_loader.sv
/*
 * Assembly of 128-bit cheat codes from the 16-bit code download
 */
`timescale 1ns/1ps
`default_nettype none
`include "cart_defs.svh"

module cheat_code_loader import cart_pkg::*; (
	input  wire                    clk_sys,
	input  wire                    reset,
	input  wire                    code_download,
	input  wire                    ioctl_wr,
	input  wire [`CART_ADDR_W-1:0] ioctl_addr,
	input  wire [`CART_DATA_W-1:0] ioctl_data,
	output cheat_code_t            code,
	output logic                   code_valid,
	output logic                   code_reset
);

	logic code_wr;

	assign code_wr = code_download & ioctl_wr;

	// Eight words per code, low half of each field first
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (ioctl_addr[3:0])
				4'd0:  code.flags[15:0]    <= ioctl_data;
				4'd2:  code.flags[31:16]   <= ioctl_data;
				4'd4:  code.address[15:0]  <= ioctl_data;
				4'd6:  code.address[31:16] <= ioctl_data;
				4'd8:  code.compare[15:0]  <= ioctl_data;
				4'd10: code.compare[31:16] <= ioctl_data;
				4'd12: code.replace[15:0]  <= ioctl_data;
				4'd14: code.replace[31:16] <= ioctl_data;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			code_valid <= 1'b0;
			code_reset <= 1'b0;
		end else begin
			code_valid <= code_wr && (ioctl_addr[3:0] == 4'd14);
			// Very first word of the download clears the old code list
			code_reset <= code_wr && (ioctl_addr == '0);
		end
	end

endmodule

`default_nettype wire

// File: logic/cart_quirk_table.sv
/*
 * Product code capture from the cartridge header and known-quirk lookup
 */
`timescale 1ns/1ps
`default_nettype none
`include "cart_defs.svh"

module cart_quirk_table import cart_pkg::*; (
	input  wire                    clk_sys,
	input  wire                    reset,
	input  wire                    cart_download,
	input  wire                    ioctl_wr,
	input  wire [`CART_ADDR_W-1:0] ioctl_addr,
	input  wire [`CART_DATA_W-1:0] ioctl_data,
	output cart_quirks_t           quirks
);

	logic                  download_q;
	logic                  hdr_wr;
	logic [`CART_ID_W-1:0] cart_id;

	assign hdr_wr = ioctl_wr & cart_download;

	////////////////////
	// Product code, first character in the top byte
	always_ff @(posedge clk_sys) begin
		if (hdr_wr) begin
			case (ioctl_addr)
				`HDR_ID_FIRST:          cart_id[63:56] <= ioctl_data[15:8];
				`HDR_ID_FIRST + 25'd2:  cart_id[55:40] <= swap_bytes(ioctl_data);
				`HDR_ID_FIRST + 25'd4:  cart_id[39:24] <= swap_bytes(ioctl_data);
				`HDR_ID_FIRST + 25'd6:  cart_id[23:8]  <= swap_bytes(ioctl_data);
				`HDR_ID_FIRST + 25'd8:  cart_id[7:0]   <= ioctl_data[7:0];
				default: ;
			endcase
		end
	end

	////////////////////
	// Lookup once the whole code is in
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			download_q <= 1'b0;
			quirks     <= '0;
		end else begin
			download_q <= cart_download;
			if (cart_download && ~download_q)
				quirks <= '0;
			if (hdr_wr && ioctl_addr == `HDR_ID_DECIDE) begin
				case (cart_id)
					// Battery RAM mapped without header info
					"T-081276", "T-81406 ", "T-081586", "T-81576 ", "T-81476 ":
						quirks.sram <= 1'b1;
					"MK-1215 ", "G-4060  ", "00001211", "MK-1228 ", "G-5538  ",
					"00004076", "T-12046 ", "T-12053 ", "G-4524  ":
						quirks.eeprom <= 1'b1;
					// Game probes for RAM that is not there
					"T-113016":
						quirks.noram <= 1'b1;
					"T-89016 ":
						quirks.fifo <= 1'b1;
					"T-574023", "T-574013":
						quirks.pier <= 1'b1;
					"TITAN002":
						quirks.ttn2 <= 1'b1;
					// SVP coprocessor carts
					"MK-1229 ", "G-7001  ":
						quirks.svp <= 1'b1;
					"T-35036 ", "T-25073 ", "MK-1137-":
						quirks.fmbusy <= 1'b1;
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/region_select.sv
/*
 * Console region choice from header letters, search priority or file index
 */
`timescale 1ns/1ps
`default_nettype none
`include "cart_defs.svh"

module region_select import cart_pkg::*; (
	input  wire                     clk_sys,
	input  wire                     reset,
	input  wire region_mode_t       region_mode,
	input  wire region_prio_t       region_prio,
	input  wire [`CART_INDEX_W-1:0] ioctl_index,
	input  wire                     hdr_j,
	input  wire                     hdr_u,
	input  wire                     hdr_e,
	input  wire                     header_ready,
	output region_t                 region,
	output logic                    region_set
);

	// First flagged region in the order, else the head of the order
	function automatic region_t pick_region(input region_prio_t prio, input logic [2:0] seen);
		region_t order [3];
		region_t pick;
		case (prio)
			PRIO_US_EU_JP: order = '{REGION_US, REGION_EU, REGION_JP};
			PRIO_EU_US_JP: order = '{REGION_EU, REGION_US, REGION_JP};
			PRIO_US_JP_EU: order = '{REGION_US, REGION_JP, REGION_EU};
			default:       order = '{REGION_JP, REGION_US, REGION_EU};
		endcase
		pick = order[0];
		for (int i = 2; i >= 0; i--) begin
			if (seen[order[i]])
				pick = order[i];
		end
		return pick;
	endfunction

	logic ready_q;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ready_q    <= 1'b0;
			region     <= REGION_JP;
			region_set <= 1'b0;
		end else begin
			ready_q <= header_ready;
			if (header_ready && ~ready_q) begin
				case (region_mode)
					MODE_HEADER: begin
						region_set <= 1'b1;
						region     <= pick_region(region_prio, {hdr_e, hdr_u, hdr_j});
					end
					// Index 0 is a plain image without a region hint
					MODE_FILE_INDEX: begin
						region_set <= |ioctl_index;
						region     <= region_t'(ioctl_index[7:6]);
					end
					default: ;
				endcase
			end
			if (~header_ready && ready_q)
				region_set <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: logic/cart_header_scan.sv
/*
 * Region letter scan over the cartridge header and header-complete flag
 */
`timescale 1ns/1ps
`default_nettype none
`include "cart_defs.svh"

module cart_header_scan import cart_pkg::*; (
	input  wire                    clk_sys,
	input  wire                    reset,
	input  wire                    cart_download,
	input  wire                    ioctl_wr,
	input  wire [`CART_ADDR_W-1:0] ioctl_addr,
	input  wire [`CART_DATA_W-1:0] ioctl_data,
	output logic                   hdr_j,
	output logic                   hdr_u,
	output logic                   hdr_e,
	output logic                   header_ready
);

	// One bit per region, indexed by region_t
	function automatic logic [2:0] letter_flags(input logic [7:0] c);
		logic [2:0] flags;
		region_t r;
		flags = 3'b000;
		if (c >= "0" && c <= "Z") begin
			if (c == "J")
				r = REGION_JP;
			else if (c == "U")
				r = REGION_US;
			else
				r = REGION_EU;
			flags[r] = 1'b1;
		end
		return flags;
	endfunction

	logic       download_q;
	logic       download_start;
	logic       region_word;
	logic [2:0] flags_old;
	logic [2:0] flags_new;

	assign download_start = cart_download & ~download_q;
	assign region_word    = (ioctl_addr == `HDR_REGION_ADDR0) ||
	                        (ioctl_addr == `HDR_REGION_ADDR1);

	// A fresh download starts from no letters seen
	assign flags_old = download_start ? 3'b000 : {hdr_e, hdr_u, hdr_j};

	always_comb begin
		flags_new = 3'b000;
		if (ioctl_wr && cart_download) begin
			if (region_word)
				flags_new = flags_new | letter_flags(ioctl_data[7:0]);
			// First region word also carries a letter in its upper byte
			if (ioctl_addr == `HDR_REGION_ADDR0)
				flags_new = flags_new | letter_flags(ioctl_data[15:8]);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			download_q   <= 1'b0;
			hdr_j        <= 1'b0;
			hdr_u        <= 1'b0;
			hdr_e        <= 1'b0;
			header_ready <= 1'b0;
		end else begin
			download_q <= cart_download;
			{hdr_e, hdr_u, hdr_j} <= flags_old | flags_new;
			if (~cart_download && download_q)
				header_ready <= 1'b0;
			else if (ioctl_wr && cart_download && ioctl_addr == `HDR_READY_ADDR)
				header_ready <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: logic/rom_write_ctrl.sv
/*
 * ROM write path with toggle request/acknowledge, host wait and ROM size latch
 */
`timescale 1ns/1ps
`default_nettype none
`include "cart_defs.svh"

module rom_write_ctrl import cart_pkg::*; (
	input  wire                     clk_sys,
	input  wire                     reset,
	input  wire                     cart_download,
	input  wire                     ioctl_wr,
	input  wire [`CART_ADDR_W-1:0]  ioctl_addr,
	input  wire [`CART_DATA_W-1:0]  ioctl_data,
	input  wire                     rom_wr_ack,
	output logic                    ioctl_wait,
	output logic                    rom_wr_req,
	output logic [`CART_ADDR_W-1:0] rom_wr_addr,
	output logic [`CART_DATA_W-1:0] rom_wr_data,
	output logic [`CART_ADDR_W-1:0] rom_size
);

	logic download_q;
	logic download_start;
	logic download_end;

	assign download_start = cart_download & ~download_q;
	assign download_end   = ~cart_download & download_q;

	////////////////////
	// Request toggle and host hold
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			download_q <= 1'b0;
			ioctl_wait <= 1'b0;
			rom_wr_req <= 1'b0;
		end else begin
			download_q <= cart_download;
			if (download_end)
				ioctl_wait <= 1'b0;
			// Memory clears its ack at the same start, a word on that cycle is a toggle from 0
			if (download_start) begin
				rom_wr_req <= ioctl_wr;
				ioctl_wait <= ioctl_wr;
			end else if (cart_download) begin
				if (ioctl_wr) begin
					rom_wr_req <= ~rom_wr_req;
					ioctl_wait <= 1'b1;
				end else if (ioctl_wait && (rom_wr_req == rom_wr_ack)) begin
					ioctl_wait <= 1'b0;
				end
			end
		end
	end

	// Last host address stands for the image size
	always_ff @(posedge clk_sys) begin
		if (download_end)
			rom_size <= ioctl_addr;
	end

	assign rom_wr_addr = cart_download ? ioctl_addr : rom_size;
	assign rom_wr_data = swap_bytes(ioctl_data);

endmodule

`default_nettype wire

// File: logic/cart_pkg.sv
/*
 * Region, auto-region mode and priority enums, quirk flags,
 * cheat code layout and the host word byte swap
 */
`default_nettype none
`include "cart_defs.svh"

package cart_pkg;

	typedef enum logic [1:0] {
		REGION_JP = 2'd0,
		REGION_US = 2'd1,
		REGION_EU = 2'd2
	} region_t;

	// Values 2 and 3 both leave the region alone
	typedef enum logic [1:0] {
		MODE_HEADER     = 2'd0,
		MODE_FILE_INDEX = 2'd1,
		MODE_DISABLED   = 2'd2
	} region_mode_t;

	// Search order for header letters
	typedef enum logic [1:0] {
		PRIO_US_EU_JP = 2'd0,
		PRIO_EU_US_JP = 2'd1,
		PRIO_US_JP_EU = 2'd2,
		PRIO_JP_US_EU = 2'd3
	} region_prio_t;

	typedef struct packed {
		logic sram;
		logic eeprom;
		logic noram;
		logic fifo;
		logic pier;
		logic ttn2;
		logic svp;
		logic fmbusy;
	} cart_quirks_t;

	// Fields in big endian order as the code generator writes them
	typedef struct packed {
		logic [`CODE_FIELD_W-1:0] flags;
		logic [`CODE_FIELD_W-1:0] address;
		logic [`CODE_FIELD_W-1:0] compare;
		logic [`CODE_FIELD_W-1:0] replace;
	} cheat_code_t;

	// Host words arrive little endian, the console bus is big endian
	function automatic logic [`CART_DATA_W-1:0] swap_bytes(input logic [`CART_DATA_W-1:0] w);
		return {w[7:0], w[15:8]};
	endfunction

endpackage

`default_nettype wire

// File: include/cart_defs.svh
/*
 * Host bus widths, cartridge header word addresses and the cheat code download index
 */
`ifndef CART_DEFS_SVH
`define CART_DEFS_SVH

// Host bus
`define CART_ADDR_W 25
`define CART_DATA_W 16
`define CART_INDEX_W 8

// Product code is 8 ASCII characters
`define CART_ID_W 64

// One field of a cheat code
`define CODE_FIELD_W 32

// Header words with region letters
`define HDR_REGION_ADDR0 25'h1F0
`define HDR_REGION_ADDR1 25'h1F2

// First word past the header
`define HDR_READY_ADDR 25'h200

// Product code words, lookup fires on the word after the code
`define HDR_ID_FIRST 25'h182
`define HDR_ID_DECIDE 25'h18C

// Download index reserved for cheat codes
`define CODE_INDEX 8'hFF

`endif
